/* hw/aq32_pkg.sv */
`default_nettype none

package aq32_pkg;

    // Bus widths
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int SAMPLE_W = 16;

    // One tick per millisecond of the 25.175 MHz clock
    localparam logic [14:0] TICK_DIV = 15'd25175;

    ////////////////////////////////////////////////////
    // Register byte addresses
    ////////////////////////////////////////////////////
    localparam logic [ADDR_W-1:0] ADDR_VCTRL     = 32'h0000_2008;
    localparam logic [ADDR_W-1:0] ADDR_VSCRX     = 32'h0000_200C;
    localparam logic [ADDR_W-1:0] ADDR_VSCRY     = 32'h0000_2010;
    localparam logic [ADDR_W-1:0] ADDR_VIRQLINE  = 32'h0000_2018;
    localparam logic [ADDR_W-1:0] ADDR_MTIME     = 32'h0000_2080;
    localparam logic [ADDR_W-1:0] ADDR_MTIMEH    = 32'h0000_2084;
    localparam logic [ADDR_W-1:0] ADDR_MTIMECMP  = 32'h0000_2088;
    localparam logic [ADDR_W-1:0] ADDR_MTIMECMPH = 32'h0000_208C;

    // Video register widths
    localparam int VCTRL_W   = 6;
    localparam int SCRX_W    = 9;
    localparam int SCRY_W    = 8;
    localparam int IRQLINE_W = 9;

    // Video control flag positions
    localparam int VCTRL_TEXT_EN       = 0;
    localparam int VCTRL_TEXT_MODE80   = 1;
    localparam int VCTRL_TEXT_PRIORITY = 2;
    localparam int VCTRL_GFX_EN        = 3;
    localparam int VCTRL_GFX_TILEMODE  = 4;
    localparam int VCTRL_SPRITES_EN    = 5;

    ////////////////////////////////////////////////////
    // Register select indices
    ////////////////////////////////////////////////////
    localparam int SEL_W = 8;
    localparam logic [2:0] SEL_VCTRL     = 3'd0;
    localparam logic [2:0] SEL_SCRX      = 3'd1;
    localparam logic [2:0] SEL_SCRY      = 3'd2;
    localparam logic [2:0] SEL_IRQLINE   = 3'd3;
    localparam logic [2:0] SEL_MTIME     = 3'd4;
    localparam logic [2:0] SEL_MTIMEH    = 3'd5;
    localparam logic [2:0] SEL_MTIMECMP  = 3'd6;
    localparam logic [2:0] SEL_MTIMECMPH = 3'd7;

    // Saturation limits
    localparam logic [SAMPLE_W-1:0] SAMPLE_MAX = 16'h7FFF;
    localparam logic [SAMPLE_W-1:0] SAMPLE_MIN = 16'h8000;

endpackage

`default_nettype wire

/* hw/bus_decode.sv */
`default_nettype none

module bus_decode (
    input  wire                          strobe,
    input  wire  [aq32_pkg::ADDR_W-1:0]  addr,
    output logic [aq32_pkg::SEL_W-1:0]   sel
);

    logic [aq32_pkg::ADDR_W-1:0] word_addr;

    // Byte offset within the word is ignored
    assign word_addr = {addr[aq32_pkg::ADDR_W-1:2], 2'b00};

    always_comb begin
        sel = '0;
        if (strobe) begin
            sel[aq32_pkg::SEL_VCTRL]     = (word_addr == aq32_pkg::ADDR_VCTRL);
            sel[aq32_pkg::SEL_SCRX]      = (word_addr == aq32_pkg::ADDR_VSCRX);
            sel[aq32_pkg::SEL_SCRY]      = (word_addr == aq32_pkg::ADDR_VSCRY);
            sel[aq32_pkg::SEL_IRQLINE]   = (word_addr == aq32_pkg::ADDR_VIRQLINE);
            sel[aq32_pkg::SEL_MTIME]     = (word_addr == aq32_pkg::ADDR_MTIME);
            sel[aq32_pkg::SEL_MTIMEH]    = (word_addr == aq32_pkg::ADDR_MTIMEH);
            sel[aq32_pkg::SEL_MTIMECMP]  = (word_addr == aq32_pkg::ADDR_MTIMECMP);
            sel[aq32_pkg::SEL_MTIMECMPH] = (word_addr == aq32_pkg::ADDR_MTIMECMPH);
        end
    end

    ////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////

    // Package addresses must all be distinct words
    sel_onehot: assert final ($onehot0(sel))
        else $error("bus_decode: more than one select active, sel=%b", sel);

endmodule

`default_nettype wire

/* hw/machine_timer.sv */
`default_nettype none

module machine_timer (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          wren,
    input  wire                          sel_lo,
    input  wire                          sel_hi,
    input  wire                          sel_cmp_lo,
    input  wire                          sel_cmp_hi,
    input  wire  [aq32_pkg::DATA_W-1:0]  wrdata,
    output logic [63:0]                  mtime,
    output logic [63:0]                  mtimecmp,
    output logic                         timer_irq
);

    logic [14:0] tick_cnt;
    logic        tick;

    ////////////////////////////////////////////////////
    // Millisecond prescaler
    ////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (tick_cnt == aq32_pkg::TICK_DIV - 15'd1) begin
                tick_cnt <= '0;
                tick     <= 1'b1;
            end else begin
                tick_cnt <= tick_cnt + 15'd1;
            end
        end
    end

    ////////////////////////////////////////////////////
    // mtime, mtimecmp and compare interrupt
    ////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mtime     <= '0;
            mtimecmp  <= '0;
            timer_irq <= 1'b0;
        end else begin
            if (tick)
                mtime <= mtime + 64'd1;

            // CPU write to a half wins over the tick
            if (wren && sel_lo)     mtime[31:0]     <= wrdata;
            if (wren && sel_hi)     mtime[63:32]    <= wrdata;
            if (wren && sel_cmp_lo) mtimecmp[31:0]  <= wrdata;
            if (wren && sel_cmp_hi) mtimecmp[63:32] <= wrdata;

            timer_irq <= (mtimecmp <= mtime);
        end
    end

    // Tick is a single-cycle pulse
    tick_single: assert property (@(posedge clk) disable iff (reset) tick |=> !tick)
        else $error("machine_timer: tick held for two cycles");

endmodule

`default_nettype wire

/* hw/video_regs.sv */
`default_nettype none

module video_regs (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              wren,
    input  wire                              sel_vctrl,
    input  wire                              sel_scrx,
    input  wire                              sel_scry,
    input  wire                              sel_irqline,
    input  wire  [aq32_pkg::DATA_W-1:0]      wrdata,
    output logic [aq32_pkg::VCTRL_W-1:0]     vctrl,
    output logic [aq32_pkg::SCRX_W-1:0]      scroll_x,
    output logic [aq32_pkg::SCRY_W-1:0]      scroll_y,
    output logic [aq32_pkg::IRQLINE_W-1:0]   irqline
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vctrl    <= '0;
            scroll_x <= '0;
            scroll_y <= '0;
            irqline  <= '0;
        end else if (wren) begin
            if (sel_vctrl) begin
                vctrl[aq32_pkg::VCTRL_TEXT_EN]       <= wrdata[aq32_pkg::VCTRL_TEXT_EN];
                vctrl[aq32_pkg::VCTRL_TEXT_MODE80]   <= wrdata[aq32_pkg::VCTRL_TEXT_MODE80];
                vctrl[aq32_pkg::VCTRL_TEXT_PRIORITY] <= wrdata[aq32_pkg::VCTRL_TEXT_PRIORITY];
                vctrl[aq32_pkg::VCTRL_GFX_EN]        <= wrdata[aq32_pkg::VCTRL_GFX_EN];
                vctrl[aq32_pkg::VCTRL_GFX_TILEMODE]  <= wrdata[aq32_pkg::VCTRL_GFX_TILEMODE];
                vctrl[aq32_pkg::VCTRL_SPRITES_EN]    <= wrdata[aq32_pkg::VCTRL_SPRITES_EN];
            end

            // Scroll registers take the low bits
            if (sel_scrx)
                scroll_x <= wrdata[aq32_pkg::SCRX_W-1:0];
            if (sel_scry)
                scroll_y <= wrdata[aq32_pkg::SCRY_W-1:0];

            // Raster IRQ line is written at its own address only
            if (sel_irqline)
                irqline <= wrdata[aq32_pkg::IRQLINE_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* hw/read_mux.sv */
`default_nettype none

module read_mux (
    input  wire  [aq32_pkg::SEL_W-1:0]      sel,
    input  wire  [aq32_pkg::VCTRL_W-1:0]    vctrl,
    input  wire  [aq32_pkg::SCRX_W-1:0]     scroll_x,
    input  wire  [aq32_pkg::SCRY_W-1:0]     scroll_y,
    input  wire  [aq32_pkg::IRQLINE_W-1:0]  irqline,
    input  wire  [63:0]                     mtime,
    input  wire  [63:0]                     mtimecmp,
    output logic [aq32_pkg::DATA_W-1:0]     rddata
);

    always_comb begin
        rddata = '0;
        if (sel[aq32_pkg::SEL_VCTRL])
            rddata = {{(aq32_pkg::DATA_W - aq32_pkg::VCTRL_W){1'b0}}, vctrl};
        if (sel[aq32_pkg::SEL_SCRX])
            rddata = {{(aq32_pkg::DATA_W - aq32_pkg::SCRX_W){1'b0}}, scroll_x};
        if (sel[aq32_pkg::SEL_SCRY])
            rddata = {{(aq32_pkg::DATA_W - aq32_pkg::SCRY_W){1'b0}}, scroll_y};
        if (sel[aq32_pkg::SEL_IRQLINE])
            rddata = {{(aq32_pkg::DATA_W - aq32_pkg::IRQLINE_W){1'b0}}, irqline};

        // Timer halves
        if (sel[aq32_pkg::SEL_MTIME])     rddata = mtime[31:0];
        if (sel[aq32_pkg::SEL_MTIMEH])    rddata = mtime[63:32];
        if (sel[aq32_pkg::SEL_MTIMECMP])  rddata = mtimecmp[31:0];
        if (sel[aq32_pkg::SEL_MTIMECMPH]) rddata = mtimecmp[63:32];
    end

    // Unmapped or idle bus reads as zero
    idle_zero: assert final (sel != '0 || rddata == '0)
        else $error("read_mux: nonzero read data with no select, rddata=%h", rddata);

endmodule

`default_nettype wire

/* hw/audio_mixer.sv */
`default_nettype none

module audio_mixer (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  signed [aq32_pkg::SAMPLE_W-1:0] pcm_l,
    input  wire  signed [aq32_pkg::SAMPLE_W-1:0] pcm_r,
    input  wire  signed [aq32_pkg::SAMPLE_W-1:0] fm_l,
    input  wire  signed [aq32_pkg::SAMPLE_W-1:0] fm_r,
    output logic signed [aq32_pkg::SAMPLE_W-1:0] mix_l,
    output logic signed [aq32_pkg::SAMPLE_W-1:0] mix_r
);

    // Clamp a sum that is one bit wider than a sample
    function automatic logic [aq32_pkg::SAMPLE_W-1:0] clamp(
        input logic [aq32_pkg::SAMPLE_W:0] sum
    );
        logic [1:0] top;
        top = sum[aq32_pkg::SAMPLE_W:aq32_pkg::SAMPLE_W-1];
        if (top == 2'b01)
            return aq32_pkg::SAMPLE_MAX;
        if (top == 2'b10)
            return aq32_pkg::SAMPLE_MIN;
        return sum[aq32_pkg::SAMPLE_W-1:0];
    endfunction

    logic signed [aq32_pkg::SAMPLE_W:0] sum_l;
    logic signed [aq32_pkg::SAMPLE_W:0] sum_r;

    assign sum_l = pcm_l + fm_l;
    assign sum_r = pcm_r + fm_r;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mix_l <= '0;
            mix_r <= '0;
        end else begin
            mix_l <= clamp(sum_l);
            mix_r <= clamp(sum_r);
        end
    end

endmodule

`default_nettype wire

/* hw/aq32_periph.sv */
`default_nettype none

module aq32_periph (
    input  wire                                  clk,
    input  wire                                  reset,

    // CPU bus
    input  wire                                  cpu_strobe,
    input  wire                                  cpu_wren,
    input  wire         [aq32_pkg::ADDR_W-1:0]   cpu_addr,
    input  wire         [aq32_pkg::DATA_W-1:0]   cpu_wrdata,
    output wire         [aq32_pkg::DATA_W-1:0]   cpu_rddata,
    output wire                                  timer_irq,

    // To video engine
    output wire         [aq32_pkg::VCTRL_W-1:0]   vctrl,
    output wire         [aq32_pkg::SCRX_W-1:0]    scroll_x,
    output wire         [aq32_pkg::SCRY_W-1:0]    scroll_y,
    output wire         [aq32_pkg::IRQLINE_W-1:0] irqline,

    // Audio streams
    input  wire  signed [aq32_pkg::SAMPLE_W-1:0] pcm_l,
    input  wire  signed [aq32_pkg::SAMPLE_W-1:0] pcm_r,
    input  wire  signed [aq32_pkg::SAMPLE_W-1:0] fm_l,
    input  wire  signed [aq32_pkg::SAMPLE_W-1:0] fm_r,
    output wire  signed [aq32_pkg::SAMPLE_W-1:0] mix_l,
    output wire  signed [aq32_pkg::SAMPLE_W-1:0] mix_r
);

    wire [aq32_pkg::SEL_W-1:0] sel;
    wire [63:0]                mtime;
    wire [63:0]                mtimecmp;

    ////////////////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////////////////
    bus_decode decode (
        .strobe(cpu_strobe), .addr(cpu_addr), .sel(sel));

    machine_timer timer (
        .clk(clk), .reset(reset), .wren(cpu_wren),
        .sel_lo(sel[aq32_pkg::SEL_MTIME]), .sel_hi(sel[aq32_pkg::SEL_MTIMEH]),
        .sel_cmp_lo(sel[aq32_pkg::SEL_MTIMECMP]), .sel_cmp_hi(sel[aq32_pkg::SEL_MTIMECMPH]),
        .wrdata(cpu_wrdata), .mtime(mtime), .mtimecmp(mtimecmp), .timer_irq(timer_irq));

    video_regs vregs (
        .clk(clk), .reset(reset), .wren(cpu_wren),
        .sel_vctrl(sel[aq32_pkg::SEL_VCTRL]), .sel_scrx(sel[aq32_pkg::SEL_SCRX]),
        .sel_scry(sel[aq32_pkg::SEL_SCRY]), .sel_irqline(sel[aq32_pkg::SEL_IRQLINE]),
        .wrdata(cpu_wrdata), .vctrl(vctrl), .scroll_x(scroll_x),
        .scroll_y(scroll_y), .irqline(irqline));

    read_mux rdmux (
        .sel(sel), .vctrl(vctrl), .scroll_x(scroll_x), .scroll_y(scroll_y),
        .irqline(irqline), .mtime(mtime), .mtimecmp(mtimecmp), .rddata(cpu_rddata));

    ////////////////////////////////////////////////////
    // Audio output side
    ////////////////////////////////////////////////////
    audio_mixer mixer (
        .clk(clk), .reset(reset),
        .pcm_l(pcm_l), .pcm_r(pcm_r), .fm_l(fm_l), .fm_r(fm_r),
        .mix_l(mix_l), .mix_r(mix_r));

endmodule

`default_nettype wire

/* bench/aq32_periph_tb.sv */
`default_nettype none

module aq32_periph_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 100;
    localparam int SAMPLE_DELAY = 90;
    localparam int WAIT_LIMIT   = 30000;
    localparam int MIX_COUNT    = 200;

    logic                                clk;
    logic                                reset;
    logic                                cpu_strobe;
    logic                                cpu_wren;
    logic        [aq32_pkg::ADDR_W-1:0]  cpu_addr;
    logic        [aq32_pkg::DATA_W-1:0]  cpu_wrdata;
    wire         [aq32_pkg::DATA_W-1:0]  cpu_rddata;
    wire                                 timer_irq;
    wire      [aq32_pkg::VCTRL_W-1:0]    vctrl;
    wire      [aq32_pkg::SCRX_W-1:0]     scroll_x;
    wire      [aq32_pkg::SCRY_W-1:0]     scroll_y;
    wire      [aq32_pkg::IRQLINE_W-1:0]  irqline;
    logic signed [aq32_pkg::SAMPLE_W-1:0] pcm_l;
    logic signed [aq32_pkg::SAMPLE_W-1:0] pcm_r;
    logic signed [aq32_pkg::SAMPLE_W-1:0] fm_l;
    logic signed [aq32_pkg::SAMPLE_W-1:0] fm_r;
    wire  signed [aq32_pkg::SAMPLE_W-1:0] mix_l;
    wire  signed [aq32_pkg::SAMPLE_W-1:0] mix_r;

    int     errors;
    int     checks;
    integer seed;

    aq32_periph DUT (
        .clk(clk), .reset(reset),
        .cpu_strobe(cpu_strobe), .cpu_wren(cpu_wren), .cpu_addr(cpu_addr),
        .cpu_wrdata(cpu_wrdata), .cpu_rddata(cpu_rddata), .timer_irq(timer_irq),
        .vctrl(vctrl), .scroll_x(scroll_x), .scroll_y(scroll_y), .irqline(irqline),
        .pcm_l(pcm_l), .pcm_r(pcm_r), .fm_l(fm_l), .fm_r(fm_r),
        .mix_l(mix_l), .mix_r(mix_r));

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Signed sum clamped to the 16-bit range
    function automatic logic [15:0] expected_mix(input logic signed [15:0] a,
                                                 input logic signed [15:0] b);
        int sum;
        sum = int'(a) + int'(b);
        if (sum > 32767)
            sum = 32767;
        else if (sum < -32768)
            sum = -32768;
        return sum[15:0];
    endfunction

    ////////////////////////////////////////////////////
    // Bus operations
    ////////////////////////////////////////////////////
    task automatic bus_op(input logic write, input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        cpu_strobe <= 1'b1;
        cpu_wren   <= write;
        cpu_addr   <= addr;
        cpu_wrdata <= data;
        #SAMPLE_DELAY;
    endtask

    // Video registers also show up on their output ports
    task automatic check_ports(input string name, input logic [31:0] addr,
                               input logic [31:0] expected);
        logic [31:0] port_word;
        port_word = '0;
        case (addr)
            aq32_pkg::ADDR_VCTRL:    port_word = vctrl;
            aq32_pkg::ADDR_VSCRX:    port_word = scroll_x;
            aq32_pkg::ADDR_VSCRY:    port_word = scroll_y;
            aq32_pkg::ADDR_VIRQLINE: port_word = irqline;
            default:                 return;
        endcase
        check_value({name, " port"}, expected, port_word);
    endtask

    task automatic wait_irq(input logic level, input string name);
        int cycles;
        cycles = 0;
        @(posedge clk);
        cpu_strobe <= 1'b0;
        cpu_wren   <= 1'b0;
        #SAMPLE_DELAY;
        while (timer_irq !== level && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #SAMPLE_DELAY;
            cycles++;
        end
        checks++;
        if (timer_irq !== level) begin
            errors++;
            $display("%s: timer_irq never reached %0b within %0d cycles", name, level, WAIT_LIMIT);
        end
    endtask

    task automatic run_trace;
        int          fd;
        int          n;
        int          line_no;
        string       line;
        string       op;
        string       name;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
        fd = $fopen("bench/aq32_periph_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the trace file");
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line_no++;
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%s %h %h %h", op, addr, data, expected);
            // Comment and blank lines do not parse into four fields
            if (n == 4) begin
                name = $sformatf("trace line %0d", line_no);
                if (op == "W") begin
                    bus_op(1'b1, addr, data);
                end else if (op == "R") begin
                    bus_op(1'b0, addr, data);
                    check_value(name, expected, cpu_rddata);
                    check_ports(name, addr, expected);
                end else if (op == "I") begin
                    wait_irq(expected[0], name);
                end else begin
                    errors++;
                    $display("%s: unknown operation %s", name, op);
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////
    // Mixer saturation
    ////////////////////////////////////////////////////
    task automatic run_mixer;
        logic signed [15:0] a_l;
        logic signed [15:0] b_l;
        logic signed [15:0] a_r;
        logic signed [15:0] b_r;
        logic        [15:0] got_l;
        logic        [15:0] got_r;
        for (int i = 0; i < MIX_COUNT + 4; i++) begin
            case (i)
                0: {a_l, b_l, a_r, b_r} = {16'h7FFF, 16'h0001, 16'h8000, 16'h8000};
                1: {a_l, b_l, a_r, b_r} = {16'h8000, 16'h8000, 16'h7FFF, 16'h0001};
                2: {a_l, b_l, a_r, b_r} = {16'h7FFF, 16'h7FFF, 16'h8000, 16'hFFFF};
                3: {a_l, b_l, a_r, b_r} = {16'h7FFF, 16'h8000, 16'h4000, 16'hC000};
                default: begin
                    a_l = $random(seed);
                    b_l = $random(seed);
                    a_r = $random(seed);
                    b_r = $random(seed);
                end
            endcase
            @(posedge clk);
            pcm_l <= a_l;
            fm_l  <= b_l;
            pcm_r <= a_r;
            fm_r  <= b_r;
            // Output is registered one cycle after the inputs
            @(posedge clk);
            #SAMPLE_DELAY;
            got_l = mix_l;
            got_r = mix_r;
            check_value($sformatf("mix_l sample %0d", i), expected_mix(a_l, b_l), got_l);
            check_value($sformatf("mix_r sample %0d", i), expected_mix(a_r, b_r), got_r);
        end
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        seed       = 32'hde57bc47;
        reset      = 1'b1;
        cpu_strobe = 1'b0;
        cpu_wren   = 1'b0;
        cpu_addr   = '0;
        cpu_wrdata = '0;
        pcm_l      = '0;
        pcm_r      = '0;
        fm_l       = '0;
        fm_r       = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        run_trace();
        run_mixer();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/aq32_periph_trace.txt */
# op addr data expected (hex). W writes data, R reads and compares with expected,
# I waits for timer_irq to equal expected bit 0
I 00000000 00000000 00000001
W 00002008 FFFFFFFF 00000000
R 00002008 00000000 0000003F
W 0000200C FFFFF1A5 00000000
R 0000200C 00000000 000001A5
W 00002018 000003FF 00000000
W 00002010 00012345 00000000
R 00002010 00000000 00000045
R 00002018 00000000 000001FF
R 00002014 00000000 00000000
R 00003008 00000000 00000000
W 00002014 FFFFFFFF 00000000
W 00003008 00000000 00000000
R 00002008 00000000 0000003F
R 00002018 00000000 000001FF
W 00002080 12345678 00000000
W 00002084 89ABCDEF 00000000
W 00002088 DEADBEEF 00000000
W 0000208C 00C0FFEE 00000000
R 00002080 00000000 12345678
R 00002084 00000000 89ABCDEF
R 00002088 00000000 DEADBEEF
R 0000208C 00000000 00C0FFEE
W 00002084 00000000 00000000
W 00002080 00000005 00000000
W 00002088 00000006 00000000
W 0000208C 00000001 00000000
I 00000000 00000000 00000000
W 0000208C 00000000 00000000
I 00000000 00000000 00000001

/* aq32_periph.f */
hw/aq32_pkg.sv
hw/bus_decode.sv
hw/machine_timer.sv
hw/video_regs.sv
hw/read_mux.sv
hw/audio_mixer.sv
hw/aq32_periph.sv
bench/aq32_periph_tb.sv

/* Bender.yml */
package:
  name: aq32_periph

sources:
  - hw/aq32_pkg.sv
  - hw/bus_decode.sv
  - hw/machine_timer.sv
  - hw/video_regs.sv
  - hw/read_mux.sv
  - hw/audio_mixer.sv
  - hw/aq32_periph.sv
  - target: simulation
    files:
      - bench/aq32_periph_tb.sv
